//--- hdl/core_pkg.sv
package core_pkg;

  parameter int XLEN       = 32;
  parameter int REG_ADDR_W = 5;

  // kept rv32i major opcodes
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_STORE  = 7'b010_0011,
    OPC_OP     = 7'b011_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_JAL    = 7'b110_1111,
    OPC_BRANCH = 7'b110_0011
  } opcode_t;

  typedef enum logic [3:0] {
    S_FETCH, S_DECODE,
    S_MEM_ADDR, S_MEM_READ, S_MEM_WB, S_MEM_WRITE,
    S_EXEC_R, S_EXEC_I, S_ALU_WB, S_JAL, S_BRANCH, S_LUI,
    S_TRAP0, S_TRAP1
  } state_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_PASS_B  // lui
  } alu_op_t;

  typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RS1} src_a_t;
  typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_CONST_4, SRC_B_ZERO} src_b_t;
  typedef enum logic [1:0] {RES_ALU_OUT, RES_ALU_RESULT, RES_MEM_DATA} result_src_t;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_t;

  // mcause encoding
  typedef enum logic [3:0] {
    ILLEGAL_INSTR = 4'd2
  } trap_cause_t;

endpackage

//--- hdl/main_fsm.sv
`timescale 1ns/1ps

module main_fsm (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic [core_pkg::XLEN-1:0] instr,
  input  logic                      zero,
  input  logic                      mem_done,
  output logic                      pc_update,
  output logic                      branch,
  output logic                      instr_write,
  output core_pkg::src_a_t          src_a,
  output core_pkg::src_b_t          src_b,
  output core_pkg::alu_op_t         alu_op,
  output core_pkg::result_src_t     result_src,
  output core_pkg::imm_kind_t       imm_kind,
  output logic                      alu_out_write,
  output logic                      reg_write,
  output logic                      mem_req,
  output logic                      mem_write,
  output logic                      adr_src_result,
  output logic                      retire,
  output logic                      trap,
  output core_pkg::trap_cause_t     trap_cause
);

  core_pkg::state_t  state, state_nxt;
  core_pkg::opcode_t opcode;
  core_pkg::alu_op_t func_op;  // op picked by funct3/funct7
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              f3_alu_ok;

  assign opcode    = core_pkg::opcode_t'(instr[6:0]);
  assign funct3    = instr[14:12];
  assign funct7    = instr[31:25];
  assign f3_alu_ok = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

  always_comb begin
    case (funct3)
      3'b000:  func_op = (opcode == core_pkg::OPC_OP && funct7[5]) ? core_pkg::ALU_SUB
                                                                   : core_pkg::ALU_ADD;
      3'b010:  func_op = core_pkg::ALU_SLT;
      3'b100:  func_op = core_pkg::ALU_XOR;
      3'b110:  func_op = core_pkg::ALU_OR;
      3'b111:  func_op = core_pkg::ALU_AND;
      default: func_op = core_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    case (opcode)
      core_pkg::OPC_STORE:  imm_kind = core_pkg::IMM_S;
      core_pkg::OPC_BRANCH: imm_kind = core_pkg::IMM_B;
      core_pkg::OPC_LUI:    imm_kind = core_pkg::IMM_U;
      core_pkg::OPC_JAL:    imm_kind = core_pkg::IMM_J;
      default:              imm_kind = core_pkg::IMM_I;  // load, op-imm
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= core_pkg::S_FETCH;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = core_pkg::S_FETCH;
    case (state)
      core_pkg::S_FETCH:     state_nxt = mem_done ? core_pkg::S_DECODE : core_pkg::S_FETCH;
      core_pkg::S_DECODE: begin
        state_nxt = core_pkg::S_TRAP0;  // anything not matched below
        case (opcode)
          core_pkg::OPC_LOAD, core_pkg::OPC_STORE:
            if (funct3 == 3'b010) state_nxt = core_pkg::S_MEM_ADDR;  // lw/sw only
          core_pkg::OPC_OP:
            if (f3_alu_ok && (funct7 == 7'b0 || (funct7 == 7'b010_0000 && funct3 == 3'b000)))
              state_nxt = core_pkg::S_EXEC_R;
          core_pkg::OPC_OP_IMM:
            if (f3_alu_ok) state_nxt = core_pkg::S_EXEC_I;
          core_pkg::OPC_LUI: state_nxt = core_pkg::S_LUI;
          core_pkg::OPC_JAL: state_nxt = core_pkg::S_JAL;
          core_pkg::OPC_BRANCH:
            if (funct3[2:1] == 2'b00) state_nxt = core_pkg::S_BRANCH;  // beq, bne
          default: ;
        endcase
      end
      core_pkg::S_MEM_ADDR:  state_nxt = (opcode == core_pkg::OPC_STORE) ? core_pkg::S_MEM_WRITE
                                                                       : core_pkg::S_MEM_READ;
      core_pkg::S_MEM_READ:  state_nxt = mem_done ? core_pkg::S_MEM_WB : core_pkg::S_MEM_READ;
      core_pkg::S_MEM_WRITE: state_nxt = mem_done ? core_pkg::S_FETCH : core_pkg::S_MEM_WRITE;
      core_pkg::S_EXEC_R, core_pkg::S_EXEC_I, core_pkg::S_JAL, core_pkg::S_LUI:
        state_nxt = core_pkg::S_ALU_WB;
      core_pkg::S_TRAP0:     state_nxt = core_pkg::S_TRAP1;
      default:               state_nxt = core_pkg::S_FETCH;  // wb, branch, trap1
    endcase
  end

  always_comb begin
    pc_update      = 1'b0;
    branch         = 1'b0;
    instr_write    = 1'b0;
    src_a          = core_pkg::SRC_A_PC;
    src_b          = core_pkg::SRC_B_ZERO;
    alu_op         = core_pkg::ALU_ADD;
    result_src     = core_pkg::RES_ALU_OUT;
    alu_out_write  = 1'b0;
    reg_write      = 1'b0;
    mem_req        = 1'b0;
    mem_write      = 1'b0;
    adr_src_result = 1'b0;
    retire         = 1'b0;
    trap           = 1'b0;
    trap_cause     = core_pkg::trap_cause_t'(4'd0);
    case (state)
      core_pkg::S_FETCH: begin
        mem_req     = 1'b1;
        src_b       = core_pkg::SRC_B_CONST_4;  // pc + 4
        pc_update   = mem_done;
        instr_write = mem_done;
      end
      core_pkg::S_DECODE: begin
        src_a         = core_pkg::SRC_A_OLD_PC;  // jump/branch target
        src_b         = core_pkg::SRC_B_IMM;
        alu_out_write = 1'b1;
      end
      core_pkg::S_MEM_ADDR: begin
        src_a         = core_pkg::SRC_A_RS1;
        src_b         = core_pkg::SRC_B_IMM;
        alu_out_write = 1'b1;
      end
      core_pkg::S_MEM_READ: begin
        mem_req        = 1'b1;
        adr_src_result = 1'b1;
      end
      core_pkg::S_MEM_WB: begin
        result_src = core_pkg::RES_MEM_DATA;
        reg_write  = 1'b1;
        retire     = 1'b1;
      end
      core_pkg::S_MEM_WRITE: begin
        mem_req        = 1'b1;
        mem_write      = 1'b1;
        adr_src_result = 1'b1;
        retire         = mem_done;
      end
      core_pkg::S_EXEC_R, core_pkg::S_EXEC_I: begin
        src_a         = core_pkg::SRC_A_RS1;
        src_b         = (state == core_pkg::S_EXEC_R) ? core_pkg::SRC_B_RS2 : core_pkg::SRC_B_IMM;
        alu_op        = func_op;
        alu_out_write = 1'b1;
      end
      core_pkg::S_ALU_WB: begin
        reg_write = 1'b1;
        retire    = 1'b1;
      end
      core_pkg::S_JAL: begin
        src_a         = core_pkg::SRC_A_OLD_PC;  // link value
        src_b         = core_pkg::SRC_B_CONST_4;
        alu_out_write = 1'b1;
        pc_update     = 1'b1;  // target still in alu_out
      end
      core_pkg::S_BRANCH: begin
        src_a  = core_pkg::SRC_A_RS1;
        src_b  = core_pkg::SRC_B_RS2;
        alu_op = core_pkg::ALU_SUB;
        branch = 1'b1;
        retire = 1'b1;
      end
      core_pkg::S_LUI: begin
        src_b         = core_pkg::SRC_B_IMM;
        alu_op        = core_pkg::ALU_PASS_B;
        alu_out_write = 1'b1;
      end
      core_pkg::S_TRAP0: begin
        trap       = 1'b1;
        trap_cause = core_pkg::ILLEGAL_INSTR;
      end
      core_pkg::S_TRAP1: begin
        pc_update = 1'b1;  // pc_unit picks the trap vector
        retire    = 1'b1;
      end
      default: ;
    endcase
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!resetn)
    state inside {[core_pkg::S_FETCH:core_pkg::S_TRAP1]});

endmodule

//--- hdl/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
  parameter logic [core_pkg::XLEN-1:0] RESET_PC    = '0,
  parameter logic [core_pkg::XLEN-1:0] TRAP_VECTOR = '0
) (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      pc_update,
  input  logic                      branch,
  input  logic                      zero,
  input  logic                      instr_write,
  input  logic                      trap,
  input  logic [core_pkg::XLEN-1:0] alu_result,
  input  logic [core_pkg::XLEN-1:0] alu_out,
  input  logic [core_pkg::XLEN-1:0] mem_data,
  output logic [core_pkg::XLEN-1:0] pc,
  output logic [core_pkg::XLEN-1:0] old_pc,
  output logic [core_pkg::XLEN-1:0] instr
);

  logic [core_pkg::XLEN-1:0] instr_q;
  logic                      instr_pending;  // fetched word still in mem_data
  logic                      trap_pending;
  logic                      take_branch;

  assign instr       = instr_pending ? mem_data : instr_q;  // decode sees the new word
  assign take_branch = branch && (zero ^ instr[12]);      // funct3[0] flips beq into bne

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pc            <= RESET_PC;
      instr_pending <= 1'b0;
      trap_pending  <= 1'b0;
    end else begin
      instr_pending <= instr_write;
      if (trap) trap_pending <= 1'b1;
      if (instr_write) begin
        pc <= alu_result;  // pc + 4
      end else if (pc_update && trap_pending) begin
        pc           <= TRAP_VECTOR;
        trap_pending <= 1'b0;
      end else if (pc_update || take_branch) begin
        pc <= alu_out;  // target from decode
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_write) old_pc <= pc;
    if (instr_pending) instr_q <= mem_data;
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic                            resetn,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
  input  logic [core_pkg::REG_ADDR_W-1:0] rd_addr,
  input  logic [core_pkg::XLEN-1:0]       rd_data,
  input  logic                            reg_write,
  output logic [core_pkg::XLEN-1:0]       rs1_data,
  output logic [core_pkg::XLEN-1:0]       rs2_data
);

  logic [core_pkg::XLEN-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
  input  logic [core_pkg::XLEN-1:0] instr,
  input  core_pkg::imm_kind_t       imm_kind,
  output logic [core_pkg::XLEN-1:0] imm
);

  always_comb begin
    case (imm_kind)
      core_pkg::IMM_S:
        imm = {{(core_pkg::XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
      core_pkg::IMM_B:
        imm = {{(core_pkg::XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      core_pkg::IMM_U:
        imm = {instr[31:12], 12'b0};
      core_pkg::IMM_J:
        imm = {{(core_pkg::XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:  // i-type
        imm = {{(core_pkg::XLEN-12){instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

//--- hdl/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
  input  logic                      clk,
  input  logic                      resetn,
  input  core_pkg::src_a_t          src_a,
  input  core_pkg::src_b_t          src_b,
  input  core_pkg::alu_op_t         alu_op,
  input  logic                      alu_out_write,
  input  core_pkg::result_src_t     result_src,
  input  logic [core_pkg::XLEN-1:0] pc,
  input  logic [core_pkg::XLEN-1:0] old_pc,
  input  logic [core_pkg::XLEN-1:0] rs1_data,
  input  logic [core_pkg::XLEN-1:0] rs2_data,
  input  logic [core_pkg::XLEN-1:0] imm,
  input  logic [core_pkg::XLEN-1:0] mem_data,
  output logic [core_pkg::XLEN-1:0] alu_result,
  output logic [core_pkg::XLEN-1:0] alu_out,
  output logic                      zero,
  output logic [core_pkg::XLEN-1:0] result
);

  logic [core_pkg::XLEN-1:0] op_a, op_b;

  always_comb begin
    case (src_a)
      core_pkg::SRC_A_PC:     op_a = pc;
      core_pkg::SRC_A_OLD_PC: op_a = old_pc;
      default:                op_a = rs1_data;
    endcase
    case (src_b)
      core_pkg::SRC_B_RS2:     op_b = rs2_data;
      core_pkg::SRC_B_IMM:     op_b = imm;
      core_pkg::SRC_B_CONST_4: op_b = core_pkg::XLEN'(4);
      default:                 op_b = '0;
    endcase
  end

  always_comb begin
    case (alu_op)
      core_pkg::ALU_ADD: alu_result = op_a + op_b;
      core_pkg::ALU_SUB: alu_result = op_a - op_b;
      core_pkg::ALU_AND: alu_result = op_a & op_b;
      core_pkg::ALU_OR:  alu_result = op_a | op_b;
      core_pkg::ALU_XOR: alu_result = op_a ^ op_b;
      core_pkg::ALU_SLT: alu_result = {{(core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default:           alu_result = op_b;  // pass b for lui
    endcase
  end

  assign zero = (alu_result == '0);  // branch compare

  always_ff @(posedge clk) begin
    if (!resetn) begin
      alu_out <= '0;
    end else if (alu_out_write) begin
      alu_out <= alu_result;
    end
  end

  always_comb begin
    case (result_src)
      core_pkg::RES_ALU_RESULT: result = alu_result;
      core_pkg::RES_MEM_DATA:   result = mem_data;
      default:                  result = alu_out;
    endcase
  end

endmodule

//--- hdl/apb_master.sv
`timescale 1ns/1ps

module apb_master (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      mem_req,
  input  logic                      mem_write,
  input  logic                      adr_src_result,
  input  logic [core_pkg::XLEN-1:0] pc,
  input  logic [core_pkg::XLEN-1:0] alu_out,
  input  logic [core_pkg::XLEN-1:0] rs2_data,
  input  logic [core_pkg::XLEN-1:0] prdata,
  input  logic                      pready,
  output logic [core_pkg::XLEN-1:0] paddr,
  output logic                      psel,
  output logic                      penable,
  output logic                      pwrite,
  output logic [core_pkg::XLEN-1:0] pwdata,
  output logic                      mem_done,
  output logic [core_pkg::XLEN-1:0] mem_data
);

  typedef enum logic [1:0] {P_IDLE, P_ACCESS, P_GAP} phase_t;
  phase_t phase;

  // setup cycle is the idle cycle that sees a request
  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase <= P_GAP;  // no setup in the first cycle out of reset
    end else begin
      case (phase)
        P_IDLE:   if (mem_req) phase <= P_ACCESS;
        P_ACCESS: if (pready) phase <= P_GAP;
        default:  phase <= P_IDLE;  // bus idle between transfers
      endcase
    end
  end

  assign psel     = (phase == P_IDLE && mem_req) || phase == P_ACCESS;
  assign penable  = (phase == P_ACCESS);
  assign mem_done = penable && pready;
  assign paddr    = adr_src_result ? alu_out : pc;
  assign pwrite   = mem_write;
  assign pwdata   = rs2_data;

  always_ff @(posedge clk) begin
    if (mem_done && !mem_write) mem_data <= prdata;
  end

  a_setup_first: assert property (@(posedge clk) disable iff (!resetn)
    penable |-> psel && $past(psel));

  // address and control held by the core while the slave stalls
  a_hold_on_wait: assert property (@(posedge clk) disable iff (!resetn)
    penable && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

//--- hdl/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter logic [core_pkg::XLEN-1:0] RESET_PC    = '0,
  parameter logic [core_pkg::XLEN-1:0] TRAP_VECTOR = 32'h0000_0100
) (
  input  logic                      clk,
  input  logic                      resetn,
  output logic [core_pkg::XLEN-1:0] paddr,
  output logic                      psel,
  output logic                      penable,
  output logic                      pwrite,
  output logic [core_pkg::XLEN-1:0] pwdata,
  input  logic [core_pkg::XLEN-1:0] prdata,
  input  logic                      pready,
  output logic                      retire,
  output logic                      trap,
  output core_pkg::trap_cause_t     trap_cause
);

  logic [core_pkg::XLEN-1:0] instr, pc, old_pc, imm, mem_data;
  logic [core_pkg::XLEN-1:0] alu_result, alu_out, result, rs1_data, rs2_data;
  logic pc_update, branch, instr_write, zero, alu_out_write, reg_write;
  logic mem_req, mem_write, adr_src_result, mem_done;
  core_pkg::src_a_t      src_a;
  core_pkg::src_b_t      src_b;
  core_pkg::alu_op_t     alu_op;
  core_pkg::result_src_t result_src;
  core_pkg::imm_kind_t   imm_kind;

  main_fsm fsm_i (.*);

  pc_unit #(.RESET_PC(RESET_PC), .TRAP_VECTOR(TRAP_VECTOR)) pc_i (.*);

  reg_file rf_i (
    .clk      (clk),
    .resetn   (resetn),
    .rs1_addr (instr[19:15]),
    .rs2_addr (instr[24:20]),
    .rd_addr  (instr[11:7]),
    .rd_data  (result),
    .reg_write(reg_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  imm_gen imm_i (.*);

  alu_stage alu_i (.*);

  apb_master apb_i (.*);

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    resetn = 1'b0;
    repeat (3) @(posedge clk);
    #1 resetn = 1'b1;
  end

endmodule

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core;

  localparam logic [31:0] RESET_PC    = 32'h0000_0000;
  localparam logic [31:0] TRAP_VECTOR = 32'h0000_0100;
  localparam int          TIMEOUT     = 2000;  // cycles per wait

  logic                      clk, resetn, psel, penable, pwrite, pready, retire, trap;
  logic [core_pkg::XLEN-1:0] paddr, pwdata, prdata;
  core_pkg::trap_cause_t     trap_cause;

  logic [31:0] mem [0:511];
  logic [31:0] exp_r [1:12];
  logic [31:0] lfsr;
  logic [31:0] setup_addr [$];
  logic        setup_wr [$];
  logic [31:0] wr_addr_q [$];
  logic [31:0] wr_data_q [$];
  logic [31:0] jal_addr;
  int          pc_w, retire_cnt, retire_at_trap, trap_cnt, trap_setup_idx, wait_left;
  logic        wait_en, in_access, last_trap, trap_retired;
  core_pkg::trap_cause_t cause_seen;

  tb_clock_gen clk_i (.clk(clk), .resetn(resetn));

  core_top #(.RESET_PC(RESET_PC), .TRAP_VECTOR(TRAP_VECTOR)) dut_i (.*);

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [core_pkg::XLEN-1:0] exp,
                            input logic [core_pkg::XLEN-1:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      fail_run("value mismatch");
    end
  endtask

  task automatic check_cause(input string name, input core_pkg::trap_cause_t exp,
                             input core_pkg::trap_cause_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      fail_run("trap cause mismatch");
    end
  endtask

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b011_0011};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b010_0011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b110_0011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b110_1111};
  endfunction

  task automatic put(input logic [31:0] word);
    mem[pc_w] = word;
    pc_w++;
  endtask

  task automatic build_programs();
    for (int i = 0; i < 512; i++) mem[i] = (i * 4) ^ 32'ha5c3_0000;  // fill by address
    mem[32'h300 >> 2] = 32'h1111_2222;
    mem[32'h304 >> 2] = 32'h0f0f_0f0f;
    pc_w = RESET_PC >> 2;
    // alu program, results in x1..x12
    put({20'h12345, 5'd1, 7'b011_0111});
    put(enc_i(12'h678, 1, 3'b000, 1, 7'b001_0011));
    put(enc_i(-12'sd5, 0, 3'b000, 2, 7'b001_0011));
    put(enc_i(12'h0ff, 1, 3'b100, 3, 7'b001_0011));  // xori
    put(enc_i(12'h0f0, 1, 3'b110, 4, 7'b001_0011));  // ori
    put(enc_i(12'hf00, 1, 3'b111, 5, 7'b001_0011));  // andi
    put(enc_i(12'h001, 2, 3'b010, 6, 7'b001_0011));  // slti
    put(enc_r(7'h00, 2, 1, 3'b000, 7));
    put(enc_r(7'h20, 2, 1, 3'b000, 8));
    put(enc_r(7'h00, 2, 1, 3'b111, 9));
    put(enc_r(7'h00, 2, 1, 3'b110, 10));
    put(enc_r(7'h00, 2, 1, 3'b100, 11));
    put(enc_r(7'h00, 1, 2, 3'b010, 12));
    for (int k = 1; k <= 12; k++) put(enc_s(12'h400 + 12'(4 * (k - 1)), 5'(k), 0));
    // expected per rv32i rules
    exp_r[1]  = (32'h12345 << 12) + 32'h678;
    exp_r[2]  = 32'd0 - 32'd5;
    exp_r[3]  = exp_r[1] ^ 32'h0ff;
    exp_r[4]  = exp_r[1] | 32'h0f0;
    exp_r[5]  = exp_r[1] & 32'hffff_ff00;
    exp_r[6]  = ($signed(exp_r[2]) < 1) ? 32'd1 : 32'd0;
    exp_r[7]  = exp_r[1] + exp_r[2];
    exp_r[8]  = exp_r[1] - exp_r[2];
    exp_r[9]  = exp_r[1] & exp_r[2];
    exp_r[10] = exp_r[1] | exp_r[2];
    exp_r[11] = exp_r[1] ^ exp_r[2];
    exp_r[12] = ($signed(exp_r[2]) < $signed(exp_r[1])) ? 32'd1 : 32'd0;
    // load and store
    put(enc_i(12'h300, 0, 3'b010, 13, 7'b000_0011));
    put(enc_i(12'h304, 0, 3'b010, 14, 7'b000_0011));
    put(enc_r(7'h00, 14, 13, 3'b000, 15));
    put(enc_s(12'h440, 15, 0));
    // control flow
    put(enc_i(12'd7, 0, 3'b000, 16, 7'b001_0011));
    put(enc_i(12'd7, 0, 3'b000, 17, 7'b001_0011));
    put(enc_b(13'd8, 17, 16, 3'b000));  // beq taken
    put(enc_s(12'h4f0, 0, 0));          // poison
    put(enc_b(13'd8, 17, 16, 3'b001));  // bne falls through
    put(enc_i(12'h055, 0, 3'b000, 18, 7'b001_0011));
    put(enc_s(12'h444, 18, 0));
    jal_addr = pc_w * 4;
    put(enc_j(21'd8, 19));
    put(enc_s(12'h4f0, 0, 0));
    put(enc_s(12'h448, 19, 0));
    put(32'hffff_ffff);
    mem[TRAP_VECTOR >> 2] = enc_j(21'(-256), 0);  // back to the start
  endtask

  // apb slave, driven 1 ns after the edge
  always @(posedge clk) begin
    #1;
    if (penable) begin
      if (!in_access) begin
        in_access = 1'b1;
        wait_left = 0;
        if (wait_en) begin
          for (int b = 0; b < 2; b++) wait_left = wait_left * 2 + int'(lfsr_bit());
        end
      end
      pready = (wait_left == 0);
      prdata = mem[paddr[10:2]];
      if (wait_left > 0) wait_left--;
    end else begin
      in_access = 1'b0;
      pready    = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (!resetn && (psel || penable)) fail_run("bus active during reset");
    if (resetn) begin
      if (psel && !penable) begin
        setup_addr.push_back(paddr);
        setup_wr.push_back(pwrite);
      end
      if (psel && penable && pready && pwrite) begin
        mem[paddr[10:2]] = pwdata;
        wr_addr_q.push_back(paddr);
        wr_data_q.push_back(pwdata);
      end
      if (retire) retire_cnt++;
      if (retire && last_trap) trap_retired = 1'b1;
      if (trap && trap_cnt == 0) begin
        cause_seen     = trap_cause;
        retire_at_trap = retire_cnt;
        trap_setup_idx = setup_addr.size();
      end
      if (trap) trap_cnt++;
      last_trap = trap;
    end
  end

  task automatic wait_write(output logic [31:0] a, output logic [31:0] d);
    int n;
    n = 0;
    while (wr_addr_q.size() == 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) fail_run("timed out waiting for a bus write");
    end
    a = wr_addr_q.pop_front();
    d = wr_data_q.pop_front();
  endtask

  task automatic wait_setups(input int count);
    int n;
    n = 0;
    while (setup_addr.size() < count) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) fail_run("timed out waiting for a bus setup cycle");
    end
  endtask

  task automatic expect_write(input string name, input logic [31:0] ea, input logic [31:0] ed);
    logic [31:0] a, d;
    wait_write(a, d);
    check_word({name, " address"}, ea, a);
    check_word({name, " data"}, ed, d);
  endtask

  task automatic reset_test();
    wait_setups(1);
    check_word("reset fetch address", RESET_PC, setup_addr[0]);
    check_word("reset fetch pwrite", 32'd0, 32'(setup_wr[0]));
  endtask

  task automatic alu_test(input string name);
    for (int k = 1; k <= 12; k++) expect_write(name, 32'h400 + 4 * (k - 1), exp_r[k]);
  endtask

  task automatic load_store_test();
    expect_write("load_store", 32'h440, 32'h1111_2222 + 32'h0f0f_0f0f);
  endtask

  task automatic control_flow_test();
    logic seen_target;
    expect_write("branch", 32'h444, 32'h55);
    expect_write("jal link", 32'h448, jal_addr + 4);
    seen_target = 1'b0;
    foreach (setup_addr[i]) begin
      if (setup_addr[i] == jal_addr + 4) fail_run("instruction after jal was fetched");
      if (setup_addr[i] == jal_addr + 8) seen_target = 1'b1;
    end
    if (!seen_target) fail_run("jal target was never fetched");
  endtask

  task automatic illegal_test();
    int n;
    n = 0;
    while (trap_cnt == 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) fail_run("timed out waiting for a trap");
    end
    wait_en = 1'b1;  // every access from here on draws wait states
    check_cause("illegal trap cause", core_pkg::ILLEGAL_INSTR, cause_seen);
    n = 0;
    while (!trap_retired) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) fail_run("trap was not followed by a retire");
    end
    check_word("trap pulse length", 32'd1, 32'(trap_cnt));
    wait_setups(trap_setup_idx + 1);
    check_word("fetch after trap", TRAP_VECTOR, setup_addr[trap_setup_idx]);
  endtask

  task automatic wait_state_test();
    alu_test("wait_states");
    // trap1 and jal, then 25 alu program instructions
    check_word("retire count", 32'd27, 32'(retire_cnt - retire_at_trap));
  endtask

  initial begin
    pready         = 1'b0;
    prdata         = '0;
    lfsr           = 32'hfa75;
    wait_en        = 1'b0;
    in_access      = 1'b0;
    wait_left      = 0;
    retire_cnt     = 0;
    trap_cnt       = 0;
    retire_at_trap = 0;
    trap_setup_idx = 0;
    last_trap      = 1'b0;
    trap_retired   = 1'b0;
    build_programs();
    reset_test();
    alu_test("alu");
    load_store_test();
    control_flow_test();
    illegal_test();
    wait_state_test();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- build.f
hdl/core_pkg.sv
hdl/main_fsm.sv
hdl/pc_unit.sv
hdl/reg_file.sv
hdl/imm_gen.sv
hdl/alu_stage.sv
hdl/apb_master.sv
hdl/core_top.sv
sim/tb_clock_gen.sv
sim/tb_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f build.f -o tb_core
out=$(./obj_dir/tb_core)
echo "$out"
echo "$out" | grep -q "=== PASS ==="
